/* Makefile */
# Verilator build and run for the dummy instruction inserter

VERILATOR ?= verilator
TOP       ?= tb_dummy_insert
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+include
design/xsecure_pkg.sv
design/xsecure_csr.sv
design/lfsr_cell.sv
design/dummy_sched.sv
design/issue_stage.sv
design/dummy_insert_top.sv
testbench/dummy_insert_props.sv
testbench/tb_dummy_insert.sv

/* design/dummy_insert_top.sv */
// Top level of the dummy instruction inserter
module dummy_insert_top
  import xsecure_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  csr_wr_t     csr_wr,
  input  logic        fetch_valid,
  input  logic [31:0] fetch_instr,
  input  logic        id_ready,
  output logic        fetch_ready,
  output issue_t      issue
);

  dummy_ctrl_t          ctrl;
  logic                 ctrl_wr;
  logic [2:0]           seed_we;
  logic [XLEN-1:0]      seed_data;
  logic [2:0][XLEN-1:0] lfsr_state;
  logic                 dummy_slot;
  logic                 dummy_issued;

  xsecure_csr csr_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .csr_wr    (csr_wr),
    .ctrl      (ctrl),
    .ctrl_wr   (ctrl_wr),
    .seed_we   (seed_we),
    .seed_data (seed_data)
  );

  // All three generators advance together on each dummy issue
  for (genvar i = 0; i < 3; i++) begin : g_lfsr
    lfsr_cell #(
      .POLY    (lfsr_poly_tbl[i]),
      .DEFAULT (lfsr_default_tbl[i])
    ) lfsr_i (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .step    (dummy_issued),
      .seed_we (seed_we[i]),
      .seed    (seed_data),
      .state   (lfsr_state[i])
    );
  end

  dummy_sched sched_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctrl         (ctrl),
    .ctrl_wr      (ctrl_wr),
    .id_ready     (id_ready),
    .fetch_valid  (fetch_valid),
    .lfsr0        (lfsr_state[0]),
    .dummy_slot   (dummy_slot),
    .dummy_issued (dummy_issued)
  );

  issue_stage issue_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .id_ready    (id_ready),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .dummy_slot  (dummy_slot),
    .lfsr_state  (lfsr_state),
    .issue       (issue),
    .fetch_ready (fetch_ready)
  );

endmodule

/* design/dummy_sched.sv */
// Counts normal issues and raises the dummy slot once the random limit is reached
module dummy_sched
  import xsecure_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  dummy_ctrl_t     ctrl,
  input  logic            ctrl_wr,
  input  logic            id_ready,
  input  logic            fetch_valid,
  input  logic [XLEN-1:0] lfsr0,
  output logic            dummy_slot,
  output logic            dummy_issued
);

  logic [5:0] freq_mask;
  logic [6:0] limit;
  logic [6:0] count;

  // N - 1 for N of 64, 32, 16, 8 or 4
  always_comb begin
    if (ctrl.freq[3]) begin
      freq_mask = 6'd63;
    end else if (ctrl.freq[2]) begin
      freq_mask = 6'd31;
    end else if (ctrl.freq[1]) begin
      freq_mask = 6'd15;
    end else if (ctrl.freq[0]) begin
      freq_mask = 6'd7;
    end else begin
      freq_mask = 6'd3;
    end
  end

  // Between 1 and N normal instructions before the next dummy
  assign limit = {1'b0, lfsr0[5:0] & freq_mask} + 7'd1;

  // A reseed may drop the limit under the count, so compare with >=
  assign dummy_slot   = ctrl.en && (count >= limit);
  assign dummy_issued = dummy_slot && id_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      count <= '0;
    end else if (dummy_issued || ctrl_wr || !ctrl.en) begin
      count <= '0;
    end else if (id_ready && fetch_valid) begin
      count <= count + 7'd1;
    end
  end

endmodule

/* design/issue_stage.sv */
// Builds the dummy instruction and registers the item sent to decode
module issue_stage
  import xsecure_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 id_ready,
  input  logic                 fetch_valid,
  input  logic [31:0]          fetch_instr,
  input  logic                 dummy_slot,
  input  logic [2:0][XLEN-1:0] lfsr_state,
  output issue_t               issue,
  output logic                 fetch_ready
);

  logic [1:0] op_sel;
  logic [4:0] rs1;
  logic [4:0] rs2;
  instr_u     dummy_word;
  issue_t     dummy_item;
  issue_t     fetch_item;

  // LFSR0 picks the operation and both source registers
  assign op_sel = lfsr_state[0][13:12];
  assign rs1    = lfsr_state[0][6:2];
  assign rs2    = lfsr_state[0][11:7];

  always_comb begin
    dummy_word = '0;
    if (op_sel == 2'd3) begin
      // BLTU with all immediate bits zero falls through to the next instruction
      dummy_word.b.opcode = OPCODE_BRANCH;
      dummy_word.b.funct3 = FUNCT3_BLTU;
      dummy_word.b.rs1    = rs1;
      dummy_word.b.rs2    = rs2;
    end else begin
      dummy_word.r.opcode = OPCODE_OP;
      dummy_word.r.rd     = 5'd0;
      dummy_word.r.rs1    = rs1;
      dummy_word.r.rs2    = rs2;
      case (op_sel)
        2'd1: begin
          dummy_word.r.funct3 = FUNCT3_AND;
          dummy_word.r.funct7 = FUNCT7_AND;
        end
        2'd2: begin
          dummy_word.r.funct3 = FUNCT3_MUL;
          dummy_word.r.funct7 = FUNCT7_MUL;
        end
        default: begin
          dummy_word.r.funct3 = FUNCT3_ADD;
          dummy_word.r.funct7 = FUNCT7_ADD;
        end
      endcase
    end
  end

  // Operands come from LFSR1 and LFSR2, x0 reads as zero
  always_comb begin
    dummy_item.valid     = 1'b1;
    dummy_item.dummy     = 1'b1;
    dummy_item.instr     = dummy_word;
    dummy_item.operand_a = (rs1 == 5'd0) ? '0 : lfsr_state[1];
    dummy_item.operand_b = (rs2 == 5'd0) ? '0 : lfsr_state[2];
  end

  always_comb begin
    fetch_item           = '0;
    fetch_item.valid     = fetch_valid;
    fetch_item.instr     = fetch_instr;
  end

  // A due dummy takes the slot and fetch waits
  assign fetch_ready = id_ready && !dummy_slot;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      issue <= '0;
    end else if (id_ready) begin
      issue <= dummy_slot ? dummy_item : fetch_item;
    end
  end

endmodule

/* design/lfsr_cell.sv */
// Seedable Galois right-shift LFSR that reloads its default on lockup
module lfsr_cell
  import xsecure_pkg::*;
#(
  parameter logic [XLEN-1:0] POLY    = lfsr_poly_tbl[0],
  parameter logic [XLEN-1:0] DEFAULT = lfsr_default_tbl[0]
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            step,
  input  logic            seed_we,
  input  logic [XLEN-1:0] seed,
  output logic [XLEN-1:0] state
);

  logic [XLEN-1:0] stepped;
  logic [XLEN-1:0] candidate;

  // Feedback taps are applied when a one shifts out
  assign stepped = state[0] ? ((state >> 1) ^ POLY) : (state >> 1);

  // A seed write wins over a step
  assign candidate = seed_we ? seed : stepped;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state <= DEFAULT;
    end else if (seed_we || step) begin
      // An all-zero state would never leave zero again
      if (candidate == '0) begin
        state <= DEFAULT;
      end else begin
        state <= candidate;
      end
    end
  end

endmodule

/* design/xsecure_csr.sv */
// Control register and seed write decode for the security CSRs
`include "dummy_cfg.svh"

module xsecure_csr
  import xsecure_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  csr_wr_t         csr_wr,
  output dummy_ctrl_t     ctrl,
  output logic            ctrl_wr,
  output logic [2:0]      seed_we,
  output logic [XLEN-1:0] seed_data
);

  // Address match against the four implemented CSRs
  always_comb begin
    ctrl_wr    = csr_wr.valid && (csr_wr.addr == `DUMMY_CSR_CPUCTRL);
    seed_we[0] = csr_wr.valid && (csr_wr.addr == `DUMMY_CSR_SEED0);
    seed_we[1] = csr_wr.valid && (csr_wr.addr == `DUMMY_CSR_SEED1);
    seed_we[2] = csr_wr.valid && (csr_wr.addr == `DUMMY_CSR_SEED2);
  end

  // Seeds go straight to the LFSRs, which take them at the same edge
  assign seed_data = csr_wr.data;

  // Only the dummy fields of cpuctrl are kept, all other bits read as zero
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ctrl <= '0;
    end else if (ctrl_wr) begin
      ctrl.en   <= csr_wr.data[`DUMMY_CPUCTRL_EN_BIT];
      ctrl.freq <= csr_wr.data[`DUMMY_CPUCTRL_FREQ_LSB +: 4];
    end
  end

endmodule

/* design/xsecure_pkg.sv */
// Shared types, instruction encodings and LFSR tables for the dummy inserter
`include "dummy_cfg.svh"

package xsecure_pkg;

  localparam int XLEN = `DUMMY_XLEN;

  // One write to the CSR file, qualified by valid
  typedef struct packed {
    logic            valid;
    logic [11:0]     addr;
    logic [XLEN-1:0] data;
  } csr_wr_t;

  // Item handed to the decode stage
  typedef struct packed {
    logic        valid;
    logic        dummy;
    logic [31:0] instr;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
  } issue_t;

  typedef struct packed {
    logic       en;
    logic [3:0] freq;
  } dummy_ctrl_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // Branch immediate is scattered over the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } instr_b_t;

  // ADD, AND and MUL read the word as R-type, BLTU as B-type
  typedef union packed {
    instr_r_t r;
    instr_b_t b;
  } instr_u;

  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [2:0] FUNCT3_ADD    = 3'b000;
  localparam logic [2:0] FUNCT3_AND    = 3'b111;
  localparam logic [2:0] FUNCT3_MUL    = 3'b000;
  localparam logic [2:0] FUNCT3_BLTU   = 3'b110;
  localparam logic [6:0] FUNCT7_ADD    = 7'b000_0000;
  localparam logic [6:0] FUNCT7_AND    = 7'b000_0000;
  localparam logic [6:0] FUNCT7_MUL    = 7'b000_0001;

  // Entry i belongs to LFSR i
  localparam logic [2:0][XLEN-1:0] lfsr_poly_tbl =
    {`DUMMY_LFSR2_POLY, `DUMMY_LFSR1_POLY, `DUMMY_LFSR0_POLY};
  localparam logic [2:0][XLEN-1:0] lfsr_default_tbl =
    {`DUMMY_LFSR2_DEFAULT, `DUMMY_LFSR1_DEFAULT, `DUMMY_LFSR0_DEFAULT};

endpackage

/* include/dummy_cfg.svh */
// CSR addresses, control field positions and LFSR polynomials and reload values
`ifndef DUMMY_CFG_SVH
`define DUMMY_CFG_SVH

// Data path width of the core
`define DUMMY_XLEN 32

// Machine-mode security CSRs
`define DUMMY_CSR_CPUCTRL 12'hBF0
`define DUMMY_CSR_SEED0   12'hBF9
`define DUMMY_CSR_SEED1   12'hBFA
`define DUMMY_CSR_SEED2   12'hBFC

// Dummy enable bit and the low end of the four-bit frequency field in cpuctrl
`define DUMMY_CPUCTRL_EN_BIT   1
`define DUMMY_CPUCTRL_FREQ_LSB 16

// Galois taps for the right-shift LFSRs, bit 31 set so a step never reaches zero
`define DUMMY_LFSR0_POLY 32'h8000_0057
`define DUMMY_LFSR1_POLY 32'h8000_0062
`define DUMMY_LFSR2_POLY 32'h8000_007A

// Values loaded at reset and on any lockup
`define DUMMY_LFSR0_DEFAULT 32'h3CA5_9E1D
`define DUMMY_LFSR1_DEFAULT 32'h7B1F_0C66
`define DUMMY_LFSR2_DEFAULT 32'hD2E4_8A31

`endif

/* testbench/dummy_insert_props.sv */
// Concurrent assertions on the issued instruction, bound to the dummy inserter top level
module dummy_insert_props
  import xsecure_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        id_ready,
  input dummy_ctrl_t ctrl,
  input issue_t      issue
);
  timeunit 1ns;
  timeprecision 100ps;

  // A dummy issued at an edge needs the enable set before that edge
  no_dummy_when_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_ready && !ctrl.en |=> !(issue.valid && issue.dummy))
    else $error("Dummy issued while dummies are disabled");

  dummy_rd_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue.valid && issue.dummy |-> issue.instr[11:7] == 5'd0)
    else $error("Dummy writes a register other than x0");

  bltu_zero_offset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue.valid && issue.dummy && issue.instr[6:0] == OPCODE_BRANCH
    |-> issue.instr[31:25] == 7'd0 && issue.instr[11:7] == 5'd0)
    else $error("Dummy branch has a nonzero offset");

  hold_in_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !id_ready |=> $stable(issue))
    else $error("Issued item changed while decode was stalled");

endmodule

bind dummy_insert_top dummy_insert_props props_i (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .id_ready (id_ready),
  .ctrl     (ctrl),
  .issue    (issue)
);

/* testbench/tb_dummy_insert.sv */
// Testbench for the dummy inserter with random stimulus, reference model, checks and timeout
`include "dummy_cfg.svh"

module tb_dummy_insert
  import xsecure_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PH0_CYCLES = 200;
  localparam int FREQ_CYCLES = 250;
  localparam int NUM_FREQ = 8;
  localparam int RAND_CYCLES = 400;
  localparam int TOTAL_CYCLES = PH0_CYCLES + NUM_FREQ * (FREQ_CYCLES + 2) + RAND_CYCLES;
  localparam int TIMEOUT_CYCLES = TOTAL_CYCLES * 2;
  localparam int FREQS [NUM_FREQ] = '{0, 1, 2, 3, 5, 7, 9, 15};
  localparam logic [31:0] RNG_POLY = 32'h8020_0003;
  localparam logic [31:0] LFSR_POLY [3] =
    '{`DUMMY_LFSR0_POLY, `DUMMY_LFSR1_POLY, `DUMMY_LFSR2_POLY};
  localparam logic [31:0] LFSR_DEFAULT [3] =
    '{`DUMMY_LFSR0_DEFAULT, `DUMMY_LFSR1_DEFAULT, `DUMMY_LFSR2_DEFAULT};

  logic        clk_i;
  logic        rst_ni;
  csr_wr_t     csr_wr;
  logic        fetch_valid;
  logic [31:0] fetch_instr;
  logic        id_ready;
  logic        fetch_ready;
  issue_t      issue;

  // Reference state that mirrors the registers of the DUT
  logic        m_en;
  logic [3:0]  m_freq;
  logic [31:0] m_lfsr [3];
  int          m_count;
  issue_t      m_issue;

  logic [31:0] rng;
  issue_t      last_issue;
  logic        prev_ready;
  logic        prev_ctrl_wr;
  logic        dummies_off;
  int          prev_n;
  int          gap;
  int          dummy_count;
  int          error_count;
  int          cycle_count;

  dummy_insert_top dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_wr      (csr_wr),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .id_ready    (id_ready),
    .fetch_ready (fetch_ready),
    .issue       (issue)
  );

  // One LFSR step per random bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], rng[0]};
      rng = rng[0] ? ((rng >> 1) ^ RNG_POLY) : (rng >> 1);
    end
    return v;
  endfunction

  function automatic int freq_to_n(input logic [3:0] f);
    if (f >= 4'd8) return 64;
    else if (f >= 4'd4) return 32;
    else if (f >= 4'd2) return 16;
    else if (f == 4'd1) return 8;
    else return 4;
  endfunction

  function automatic logic [31:0] lfsr_advance(input logic [31:0] s, input logic [31:0] poly);
    return s[0] ? ((s >> 1) ^ poly) : (s >> 1);
  endfunction

  // The gap limit is LFSR0 modulo N plus one
  function automatic logic slot_due();
    int limit;
    limit = int'(m_lfsr[0] % 32'(freq_to_n(m_freq))) + 1;
    return m_en && (m_count >= limit);
  endfunction

  function automatic issue_t make_dummy(input logic [31:0] l0, l1, l2);
    issue_t     item;
    logic [4:0] rs1;
    logic [4:0] rs2;
    rs1 = l0[6:2];
    rs2 = l0[11:7];
    item.valid = 1'b1;
    item.dummy = 1'b1;
    case (l0[13:12])
      2'd0: item.instr = {7'b0000000, rs2, rs1, 3'b000, 5'd0, 7'b0110011};
      2'd1: item.instr = {7'b0000000, rs2, rs1, 3'b111, 5'd0, 7'b0110011};
      2'd2: item.instr = {7'b0000001, rs2, rs1, 3'b000, 5'd0, 7'b0110011};
      default: item.instr = {7'b0000000, rs2, rs1, 3'b110, 5'd0, 7'b1100011};
    endcase
    item.operand_a = (rs1 == 5'd0) ? 32'd0 : l1;
    item.operand_b = (rs2 == 5'd0) ? 32'd0 : l2;
    return item;
  endfunction

  function automatic csr_wr_t ctrl_write(input logic en, input int freq);
    csr_wr_t w;
    w = '0;
    w.valid = 1'b1;
    w.addr = `DUMMY_CSR_CPUCTRL;
    w.data[`DUMMY_CPUCTRL_EN_BIT] = en;
    w.data[`DUMMY_CPUCTRL_FREQ_LSB +: 4] = 4'(freq);
    return w;
  endfunction

  function automatic csr_wr_t seed_write(input int idx, input logic [31:0] data);
    csr_wr_t w;
    w.valid = 1'b1;
    w.addr = (idx == 0) ? `DUMMY_CSR_SEED0 : (idx == 1) ? `DUMMY_CSR_SEED1 : `DUMMY_CSR_SEED2;
    w.data = data;
    return w;
  endfunction

  // About one cycle in sixteen carries a CSR write and a quarter of the seeds are zero
  function automatic csr_wr_t random_csr(input logic allow_ctrl);
    csr_wr_t    w;
    logic [1:0] sel;
    w = '0;
    if (rand_bits(4) == 32'd0) begin
      sel = 2'(rand_bits(2));
      if (sel == 2'd0 && !allow_ctrl) sel = 2'd1;
      if (sel == 2'd0) begin
        w.valid = 1'b1;
        w.addr = `DUMMY_CSR_CPUCTRL;
        w.data = rand_bits(32);
      end else begin
        w = seed_write(int'(sel) - 1, (rand_bits(2) == 32'd0) ? 32'd0 : rand_bits(32));
      end
    end
    return w;
  endfunction

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Stopped after a failure");
  endtask

  task automatic check_outputs();
    if (!prev_ready) check_value(128'(issue), 128'(last_issue), "issue held in stall");
    if (dummies_off && issue.dummy) report_failure("A dummy was issued while dummies were off");
    check_value(128'(fetch_ready), 128'(id_ready && !slot_due()), "fetch_ready");
    check_value(128'(issue), 128'(m_issue), "issue");
    // A control write restarts the count of normal instructions between dummies
    if (prev_ctrl_wr) begin
      gap = 0;
    end else if (prev_ready && issue.valid) begin
      if (issue.dummy) begin
        if (gap > prev_n) begin
          report_failure($sformatf("%0d normal instructions between dummies, limit %0d",
                                   gap, prev_n));
        end
        gap = 0;
        dummy_count++;
      end else begin
        gap++;
      end
    end
    last_issue = issue;
  endtask

  // Advances the model by one clock edge using the inputs of the current cycle
  task automatic model_step();
    logic        slot;
    logic        issued;
    logic        ctrl_wr;
    logic [2:0]  seed_we;
    logic [31:0] cand;
    slot = slot_due();
    issued = slot && id_ready;
    ctrl_wr = csr_wr.valid && (csr_wr.addr == `DUMMY_CSR_CPUCTRL);
    seed_we[0] = csr_wr.valid && (csr_wr.addr == `DUMMY_CSR_SEED0);
    seed_we[1] = csr_wr.valid && (csr_wr.addr == `DUMMY_CSR_SEED1);
    seed_we[2] = csr_wr.valid && (csr_wr.addr == `DUMMY_CSR_SEED2);
    prev_ready = id_ready;
    prev_ctrl_wr = ctrl_wr;
    prev_n = freq_to_n(m_freq);
    if (id_ready && slot) begin
      m_issue = make_dummy(m_lfsr[0], m_lfsr[1], m_lfsr[2]);
    end else if (id_ready) begin
      m_issue = '0;
      m_issue.valid = fetch_valid;
      m_issue.instr = fetch_instr;
    end
    if (issued || ctrl_wr || !m_en) m_count = 0;
    else if (id_ready && fetch_valid) m_count = m_count + 1;
    for (int i = 0; i < 3; i++) begin
      if (seed_we[i] || issued) begin
        cand = seed_we[i] ? csr_wr.data : lfsr_advance(m_lfsr[i], LFSR_POLY[i]);
        m_lfsr[i] = (cand == 32'd0) ? LFSR_DEFAULT[i] : cand;
      end
    end
    if (ctrl_wr) begin
      m_en = csr_wr.data[`DUMMY_CPUCTRL_EN_BIT];
      m_freq = csr_wr.data[`DUMMY_CPUCTRL_FREQ_LSB +: 4];
    end
  endtask

  task automatic drive_cycle(input csr_wr_t wr);
    @(posedge clk_i);
    csr_wr      <= wr;
    fetch_valid <= (rand_bits(2) != 32'd0);
    id_ready    <= (rand_bits(2) != 32'd0);
    fetch_instr <= rand_bits(32);
    @(negedge clk_i);
    check_outputs();
    model_step();
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "Timeout");
  end

  initial begin
    rst_ni = 1'b0;
    csr_wr = '0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    id_ready = 1'b0;
    rng = 32'd70;
    m_en = 1'b0;
    m_freq = '0;
    m_count = 0;
    m_issue = '0;
    for (int i = 0; i < 3; i++) m_lfsr[i] = LFSR_DEFAULT[i];
    last_issue = '0;
    prev_ready = 1'b0;
    prev_ctrl_wr = 1'b0;
    prev_n = 4;
    gap = 0;
    dummy_count = 0;
    error_count = 0;
    dummies_off = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (PH0_CYCLES) drive_cycle('0);
    dummies_off = 1'b0;
    // Each frequency range is enabled and then followed by a zero seed write
    for (int p = 0; p < NUM_FREQ; p++) begin
      drive_cycle(ctrl_write(1'b1, FREQS[p]));
      drive_cycle(seed_write(p % 3, 32'd0));
      repeat (FREQ_CYCLES) drive_cycle(random_csr(1'b0));
    end
    repeat (RAND_CYCLES) drive_cycle(random_csr(1'b1));
    if (dummy_count == 0) report_failure("No dummy instruction was issued during the run");
    if (error_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "Checks failed");
    end
  end

endmodule
